// File: verilog/trigTestPkg.sv
package trigTestPkg;

    //////////////////////////////////////////////////
    // Counter and delay widths
    //////////////////////////////////////////////////

    // Pulse and trigger counters
    localparam int CountWidth = 16;

    // Trigger window delay, in clock cycles
    localparam int DelayWidth = 4;

    //////////////////////////////////////////////////
    // Test configuration
    //////////////////////////////////////////////////

    // Held stable by the host while Start is high
    typedef struct packed {
        logic [CountWidth-1:0] cptMax;
        logic [DelayWidth-1:0] triggerDelay;
    } testConfig;

    //////////////////////////////////////////////////
    // Per-discriminator result
    //////////////////////////////////////////////////

    // Pulse count goes out first in the record
    typedef struct packed {
        logic [CountWidth-1:0] pulseCount;
        logic [CountWidth-1:0] trigCount;
    } channelResult;

endpackage

// File: verilog/daqRecordPkg.sv
package daqRecordPkg;

    //////////////////////////////////////////////////
    // Record words
    //////////////////////////////////////////////////

    // One word per handshake on the output bus
    typedef logic [15:0] recordWord;

    // First word of every record
    localparam recordWord RecordHeader = 16'h4343;

    //////////////////////////////////////////////////
    // Output handshake state
    //////////////////////////////////////////////////

    // IDLE waits for a capture
    // REQ holds the request until the receiver acknowledges
    // WAIT_ACK_LOW waits for the acknowledge to drop
    // DONE marks the end of the record for one cycle
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        DONE
    } shiftPhase;

endpackage

// File: verilog/efficiencyCounter.sv
`timescale 1ns/1ps

module efficiencyCounter import trigTestPkg::*; (
    input  logic         Clk,
    input  logic         reset_n,
    input  testConfig    Cfg,
    input  logic         CountClear,
    input  logic         CountEnable,
    input  logic         ExtPulse,
    input  logic         TriggerB,
    output channelResult Result,
    output logic         Done
);

    // One extra bit so that triggerDelay+1 fits
    localparam int TimerWidth = DelayWidth + 1;

    logic                  extPulseDly;
    logic                  triggerDly;
    logic                  pulseEdge;
    logic                  triggerFall;
    logic                  pulseAccept;
    logic                  windowOpen;
    logic                  trigHit;
    logic [TimerWidth-1:0] windowLength;
    logic [TimerWidth-1:0] windowTimer;
    logic [CountWidth-1:0] pulseCount;
    logic [CountWidth-1:0] trigCount;
    logic                  doneFlag;

    //////////////////////////////////////////////////
    // Edge detection
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            extPulseDly <= 1'b0;
            // Discriminator output idles high
            triggerDly  <= 1'b1;
        end else begin
            extPulseDly <= ExtPulse;
            triggerDly  <= TriggerB;
        end
    end

    assign pulseEdge   = ExtPulse & ~extPulseDly;
    assign triggerFall = triggerDly & ~TriggerB;

    // Pulses beyond cptMax are ignored
    assign pulseAccept = pulseEdge && CountEnable && (pulseCount != Cfg.cptMax);

    //////////////////////////////////////////////////
    // Trigger window
    //////////////////////////////////////////////////

    assign windowLength = {1'b0, Cfg.triggerDelay} + TimerWidth'(1);
    assign windowOpen   = (windowTimer != '0);

    // Only the first falling edge in a window counts
    assign trigHit = triggerFall && windowOpen;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            windowTimer <= '0;
        end else if (CountClear) begin
            windowTimer <= '0;
        end else if (pulseAccept) begin
            windowTimer <= windowLength;
        end else if (trigHit) begin
            windowTimer <= '0;
        end else if (windowOpen) begin
            windowTimer <= windowTimer - TimerWidth'(1);
        end
    end

    //////////////////////////////////////////////////
    // Pulse and trigger counters
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pulseCount <= '0;
            trigCount  <= '0;
        end else if (CountClear) begin
            pulseCount <= '0;
            trigCount  <= '0;
        end else begin
            if (pulseAccept) begin
                pulseCount <= pulseCount + CountWidth'(1);
            end
            if (trigHit) begin
                trigCount <= trigCount + CountWidth'(1);
            end
        end
    end

    // Done once the last window has closed
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            doneFlag <= 1'b0;
        end else if (CountClear) begin
            doneFlag <= 1'b0;
        end else if (CountEnable && (pulseCount == Cfg.cptMax) && !windowOpen) begin
            doneFlag <= 1'b1;
        end
    end

    assign Result.pulseCount = pulseCount;
    assign Result.trigCount  = trigCount;
    assign Done              = doneFlag;

endmodule

// File: verilog/testSequencer.sv
`timescale 1ns/1ps

module testSequencer #(
    parameter int NumChannels = 3
) (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   Start,
    input  logic [NumChannels-1:0] AllDone,
    input  logic                   RecordSent,
    output logic                   CountClear,
    output logic                   CountEnable,
    output logic                   Capture,
    output logic                   TestDone
);

    //////////////////////////////////////////////////
    // Test states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        COUNT,
        CAPTURE,
        SEND,
        DONE
    } seqState;

    seqState state;
    seqState nextState;
    logic    allChannelsDone;

    // Every discriminator has seen cptMax pulses
    assign allChannelsDone = &AllDone;

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (Start) begin
                    nextState = CLEAR;
                end
            end
            // One cycle of counter clear
            CLEAR: begin
                nextState = COUNT;
            end
            COUNT: begin
                if (allChannelsDone) begin
                    nextState = CAPTURE;
                end
            end
            // Results latched by the shifter here
            CAPTURE: begin
                nextState = SEND;
            end
            SEND: begin
                if (RecordSent) begin
                    nextState = DONE;
                end
            end
            // Acknowledge of Start, released when Start drops
            DONE: begin
                if (!Start) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // Decoded straight from the state register
    assign CountClear  = (state == CLEAR);
    assign CountEnable = (state == COUNT);
    assign Capture     = (state == CAPTURE);
    assign TestDone    = (state == DONE);

endmodule

// File: verilog/recordShifter.sv
`timescale 1ns/1ps

module recordShifter import trigTestPkg::*, daqRecordPkg::*; #(
    parameter int NumChannels = 3
) (
    input  logic         Clk,
    input  logic         reset_n,
    input  logic         Capture,
    input  channelResult Results [NumChannels],
    input  logic         DataAck,
    output recordWord    DataWord,
    output logic         DataReq,
    output logic         RecordSent
);

    // Header plus two counts per discriminator
    localparam int NumWords   = 1 + 2 * NumChannels;
    localparam int IndexWidth = $clog2(NumWords);
    localparam logic [IndexWidth-1:0] LastIndex = IndexWidth'(NumWords - 1);

    recordWord             wordFile [NumWords];
    logic [IndexWidth-1:0] wordIndex;
    shiftPhase             phase;

    //////////////////////////////////////////////////
    // Word register file
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (Capture) begin
            wordFile[0] <= RecordHeader;
            for (int ch = 0; ch < NumChannels; ch++) begin
                wordFile[1 + 2 * ch] <= Results[ch].pulseCount;
                wordFile[2 + 2 * ch] <= Results[ch].trigCount;
            end
        end
    end

    //////////////////////////////////////////////////
    // Four-phase handshake
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            phase     <= IDLE;
            wordIndex <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    if (Capture) begin
                        wordIndex <= '0;
                        phase     <= REQ;
                    end
                end
                REQ: begin
                    if (DataAck) begin
                        phase <= WAIT_ACK_LOW;
                    end
                end
                // Next request only once the acknowledge is low
                WAIT_ACK_LOW: begin
                    if (!DataAck) begin
                        if (wordIndex == LastIndex) begin
                            phase <= DONE;
                        end else begin
                            wordIndex <= wordIndex + IndexWidth'(1);
                            phase     <= REQ;
                        end
                    end
                end
                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

    // Word stays stable while the request is high
    assign DataWord   = wordFile[wordIndex];
    assign DataReq    = (phase == REQ);
    assign RecordSent = (phase == DONE);

endmodule

// File: verilog/trigEfficiencyTop.sv
`timescale 1ns/1ps

module trigEfficiencyTop import trigTestPkg::*, daqRecordPkg::*; #(
    parameter int NumChannels = 3
) (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   Start,
    input  testConfig              Config,
    input  logic                   ExtPulse,
    input  logic [NumChannels-1:0] TriggerB,
    input  logic                   DataAck,
    output recordWord              DataWord,
    output logic                   DataReq,
    output logic                   TestDone
);

    logic                   countClear;
    logic                   countEnable;
    logic                   capture;
    logic                   recordSent;
    logic [NumChannels-1:0] chanDone;
    channelResult           chanResult [NumChannels];

    //////////////////////////////////////////////////
    // Test control
    //////////////////////////////////////////////////

    testSequencer #(
        .NumChannels(NumChannels)
    ) uSequencer (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .Start      (Start),
        .AllDone    (chanDone),
        .RecordSent (recordSent),
        .CountClear (countClear),
        .CountEnable(countEnable),
        .Capture    (capture),
        .TestDone   (TestDone)
    );

    //////////////////////////////////////////////////
    // One counter per discriminator
    //////////////////////////////////////////////////

    for (genvar ch = 0; ch < NumChannels; ch++) begin : genChannel
        efficiencyCounter uCounter (
            .Clk        (Clk),
            .reset_n    (reset_n),
            .Cfg        (Config),
            .CountClear (countClear),
            .CountEnable(countEnable),
            .ExtPulse   (ExtPulse),
            .TriggerB   (TriggerB[ch]),
            .Result     (chanResult[ch]),
            .Done       (chanDone[ch])
        );
    end

    // Record readout
    recordShifter #(
        .NumChannels(NumChannels)
    ) uShifter (
        .Clk       (Clk),
        .reset_n   (reset_n),
        .Capture   (capture),
        .Results   (chanResult),
        .DataAck   (DataAck),
        .DataWord  (DataWord),
        .DataReq   (DataReq),
        .RecordSent(recordSent)
    );

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int ClockPeriod = 100,
    parameter int ResetCycles = 2
) (
    output logic Clk,
    output logic reset_n
);

    initial begin
        Clk = 1'b0;
        forever #(ClockPeriod / 2) Clk = ~Clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        @(negedge Clk);
        reset_n = 1'b1;
    end

endmodule

// File: testbench/recordChecker.sv
`timescale 1ns/1ps

module recordChecker import daqRecordPkg::*; #(
    parameter int NumWords = 7
) (
    input  logic                     Clk,
    input  logic                     reset_n,
    input  logic                     Start,
    input  logic                     DataReq,
    input  logic                     DataAck,
    input  recordWord                DataWord,
    input  logic                     TestDone,
    input  recordWord [NumWords-1:0] Expect,
    output int                       errorCount,
    output int                       recordCount
);

    logic      reqDly;
    logic      ackDly;
    logic      doneDly;
    logic      resetSeen;
    recordWord heldWord;
    int        wordIndex;

    initial begin
        errorCount  = 0;
        recordCount = 0;
        wordIndex   = 0;
        resetSeen   = 1'b0;
        reqDly      = 1'b0;
        ackDly      = 1'b0;
        doneDly     = 1'b0;
        heldWord    = '0;
    end

    always @(posedge Clk) begin
        if (reset_n) begin
            if (!resetSeen && (DataReq || TestDone)) begin
                $display("DataReq or TestDone is high right after reset at %0t", $time);
                errorCount++;
            end
            resetSeen = 1'b1;
            // Host holds Start for the whole record
            if (DataReq && !Start) begin
                $display("Output request raised while Start is low at %0t", $time);
                errorCount++;
            end
            // A new request needs the previous acknowledge released
            if (DataReq && !reqDly && ackDly) begin
                $display("DataReq raised before DataAck was released at %0t", $time);
                errorCount++;
            end
            if (DataReq && !reqDly) begin
                if (wordIndex >= NumWords) begin
                    $display("Record has more than %0d words at %0t", NumWords, $time);
                    errorCount++;
                end else if (DataWord !== Expect[wordIndex]) begin
                    $display("Error at %0t: word %0d is %h, expected %h",
                             $time, wordIndex, DataWord, Expect[wordIndex]);
                    errorCount++;
                end
                heldWord = DataWord;
                wordIndex++;
            end else if (DataReq && (DataWord !== heldWord)) begin
                $display("Error at %0t: DataWord changed from %h to %h during a request",
                         $time, heldWord, DataWord);
                errorCount++;
            end
            // End of record
            if (TestDone && !doneDly) begin
                if (wordIndex != NumWords) begin
                    $display("Record ended after %0d words instead of %0d at %0t",
                             wordIndex, NumWords, $time);
                    errorCount++;
                end
                recordCount++;
                wordIndex = 0;
            end
        end
        reqDly  = DataReq;
        ackDly  = DataAck;
        doneDly = TestDone;
    end

endmodule

// File: testbench/trigEfficiencyTb.sv
`timescale 1ns/1ps

module trigEfficiencyTb import trigTestPkg::*, daqRecordPkg::*; ();

    localparam int NumChannels = 3;
    localparam int NumWords    = 1 + 2 * NumChannels;
    localparam int PulsePeriod = 24;
    localparam int MaxPulses   = 64;
    // Sum of cptMax over tests 2 to 5 with test 5 run twice
    localparam int TotalPulses   = 10 + 40 + 12 + 2 * 15;
    localparam int TimeoutCycles = TotalPulses * PulsePeriod + 5 * NumWords * 12 + 400;

    typedef struct packed {
        logic       fire;
        logic [4:0] offset;
    } firingEntry;
    typedef firingEntry firingPlan [MaxPulses][NumChannels];
    typedef recordWord [NumWords-1:0] recordImage;

    logic                   Clk;
    logic                   reset_n;
    logic                   Start;
    logic                   ExtPulse;
    logic                   DataAck;
    logic                   DataReq;
    logic                   TestDone;
    logic [NumChannels-1:0] TriggerB;
    testConfig              Config;
    recordWord              DataWord;
    recordImage             expected;
    firingPlan              plan;
    logic [31:0]            lfsrState = 32'hfc67_19fb;
    logic                   slowAck;
    int                     errorCount;
    int                     recordCount;
    int                     cycleCount;
    int                     testNumber;
    int                     testsFailed;
    int                     errorsBefore;

    clockGen uClock (.Clk(Clk), .reset_n(reset_n));

    trigEfficiencyTop #(.NumChannels(NumChannels)) UUT (.*);

    recordChecker #(.NumWords(NumWords)) uChecker (.Expect(expected), .*);

    //////////////////////////////////////////////////
    // Random source and reference
    //////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic buildPlan(input logic randomFire, input int fixedOffset);
        int bits;
        for (int p = 0; p < MaxPulses; p++) begin
            for (int ch = 0; ch < NumChannels; ch++) begin
                if (randomFire) begin
                    takeBits(1, bits);
                    plan[p][ch].fire = bits[0];
                    takeBits(5, bits);
                    plan[p][ch].offset = 5'(bits % 20 + 1);
                end else begin
                    plan[p][ch].fire   = 1'b1;
                    plan[p][ch].offset = 5'(fixedOffset);
                end
            end
        end
    endtask

    function automatic recordImage expectRecord(input firingPlan fp, input testConfig c);
        recordImage rec;
        int         hits;
        rec[0] = RecordHeader;
        for (int ch = 0; ch < NumChannels; ch++) begin
            hits = 0;
            // Window covers offsets 1 to triggerDelay+1
            for (int p = 0; p < int'(c.cptMax); p++) begin
                if (fp[p][ch].fire && int'(fp[p][ch].offset) <= int'(c.triggerDelay) + 1) begin
                    hits++;
                end
            end
            rec[1 + 2 * ch] = c.cptMax;
            rec[2 + 2 * ch] = 16'(hits);
        end
        return rec;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic runRecord(input int cptMax, input int delay);
        Config.cptMax       = 16'(cptMax);
        Config.triggerDelay = 4'(delay);
        expected = expectRecord(plan, Config);
        Start    = 1'b1;
        // Counters are enabled two cycles after Start
        repeat (3) @(negedge Clk);
        for (int p = 0; p < cptMax; p++) begin
            for (int c = 0; c < PulsePeriod; c++) begin
                ExtPulse = (c == 0);
                for (int ch = 0; ch < NumChannels; ch++) begin
                    TriggerB[ch] = !(plan[p][ch].fire && int'(plan[p][ch].offset) == c);
                end
                @(negedge Clk);
            end
        end
        while (!TestDone) @(negedge Clk);
        Start = 1'b0;
        while (TestDone) @(negedge Clk);
    endtask

    task automatic finishTest(input string name);
        testNumber++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
        end
        $display("Test %0d %s: %s", testNumber, name,
                 (errorCount != errorsBefore) ? "FAILED" : "passed");
        errorsBefore = errorCount;
    endtask

    // Ack after 1 to 4 cycles or 5 to 8 under back-pressure
    initial begin
        int ackDelay;
        DataAck = 1'b0;
        forever begin
            @(negedge Clk);
            if (DataReq) begin
                takeBits(2, ackDelay);
                ackDelay = ackDelay + (slowAck ? 5 : 1);
                repeat (ackDelay - 1) @(negedge Clk);
                DataAck = 1'b1;
                while (DataReq) @(negedge Clk);
                // Slow receiver also releases the acknowledge late
                if (slowAck) begin
                    repeat (2) @(negedge Clk);
                end
                DataAck = 1'b0;
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: tests still running after %0d clock cycles", TimeoutCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        Start        = 1'b0;
        Config       = '0;
        ExtPulse     = 1'b0;
        TriggerB     = '1;
        expected     = '0;
        slowAck      = 1'b0;
        testNumber   = 0;
        testsFailed  = 0;
        errorsBefore = 0;
        @(posedge reset_n);
        // Checker flags any request on the idle bus
        repeat (20) @(negedge Clk);
        finishTest("reset state");
        buildPlan(1'b0, 2);
        runRecord(10, 4);
        finishTest("full efficiency");
        buildPlan(1'b1, 0);
        runRecord(40, 7);
        finishTest("random firing");
        buildPlan(1'b0, 3);
        runRecord(12, 0);
        finishTest("late triggers");
        slowAck = 1'b1;
        buildPlan(1'b1, 0);
        runRecord(15, 5);
        // Second run must start from cleared counters
        slowAck = 1'b0;
        buildPlan(1'b1, 0);
        runRecord(15, 5);
        finishTest("back-pressure and restart");
        $display("Tests run: %0d, failed: %0d, errors: %0d, records: %0d",
                 testNumber, testsFailed, errorCount, recordCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/trigTestPkg.sv
verilog/daqRecordPkg.sv
verilog/efficiencyCounter.sv
verilog/testSequencer.sv
verilog/recordShifter.sv
verilog/trigEfficiencyTop.sv
testbench/clockGen.sv
testbench/recordChecker.sv
testbench/trigEfficiencyTb.sv

// File: run.sh
#!/bin/sh
# Build and run the trigger efficiency testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module trigEfficiencyTb --Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
